/* flist.f */
+incdir+hw
hw/cpu_bus_pkg.sv
hw/cpu_isa_pkg.sv
hw/bus_cycle_unit.sv
hw/bus_arbiter.sv
hw/fetch_unit.sv
hw/restart_unit.sv
hw/cpu_top.sv
verif/cpu_asserts.sv
verif/tb_cpu.sv

/* Bender.yml */
package:
  name: gb_cpu_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpu_bus_pkg.sv
      - hw/cpu_isa_pkg.sv
      - hw/bus_cycle_unit.sv
      - hw/bus_arbiter.sv
      - hw/fetch_unit.sv
      - hw/restart_unit.sv
      - hw/cpu_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/cpu_asserts.sv
      - verif/tb_cpu.sv

/* verif/tb_cpu.sv */
`include "cpu_cfg.svh"

module tb_cpu;

    localparam logic [7:0] op_bad = 8'hD3;   // Outside the decoded subset
    localparam int         limit  = 400;

    logic                   clk;
    logic                   rst;
    logic                   phi;
    logic [`CPU_ADDR_W-1:0] a;
    logic [`CPU_DATA_W-1:0] dout;
    logic [`CPU_DATA_W-1:0] din;
    logic                   rd;
    logic                   wr;
    logic [`CPU_INT_N-1:0]  int_en;
    logic [`CPU_INT_N-1:0]  int_flags_in;
    logic [`CPU_INT_N-1:0]  int_flags_out;
    logic [`CPU_DATA_W-1:0] key_in;
    logic                   done;
    logic                   fault;
    logic [7:0]             mem [0:65535];
    integer                 seed;
    int                     n1;
    int                     n2;

    cpu_top u_cpu_top (
        .clk, .rst, .phi, .a, .dout, .din, .rd, .wr,
        .int_en, .int_flags_in, .int_flags_out, .key_in, .done, .fault
    );

    bind cpu_top cpu_asserts u_cpu_asserts (.*);

    always #2 clk = ~clk;

    // Memory answers on the falling edge
    always @(negedge clk) begin
        if (wr) mem[a] <= dout;
        din <= rd ? mem[a] : '0;
    end

    always @(negedge clk) begin
        if (u_cpu_top.u_cpu_asserts.any_failed) abort_run("an assertion in cpu_asserts failed");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic load_program();
        int            i;
        logic [15:0]   p;
        for (i = 0; i < 65536; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
        end
        p = 16'h0000;
        repeat (n1) begin
            mem[p] = `CPU_OP_NOP;
            p++;
        end
        mem[p]     = `CPU_OP_EI;
        mem[p + 1] = {`CPU_RST_X, 3'd2, `CPU_RST_Z};   // RST 10h
        mem[16'h0010] = `CPU_OP_NOP;
        mem[16'h0011] = `CPU_OP_HALT;
        mem[16'h0050] = `CPU_OP_STOP;                  // Vector of bit 2
        mem[16'h0051] = `CPU_OP_EI;
        mem[16'h0052] = `CPU_OP_DI;
        p = 16'h0053;
        repeat (n2) begin
            mem[p] = `CPU_OP_NOP;
            p++;
        end
        mem[p] = op_bad;
    endtask

    task automatic wait_read(input logic [15:0] addr);
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge clk);
            seen = rd && (a == addr);
            n++;
        end
        if (!seen) abort_run($sformatf("timeout waiting for a read at %h", addr));
    endtask

    task automatic wait_flag_clear();
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge clk);
            seen = (int_flags_out != int_flags_in);
            n++;
        end
        if (!seen) abort_run("timeout waiting for the serviced flag to clear");
    endtask

    task automatic wait_end();
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge clk);
            seen = fault && done;
            n++;
        end
        if (!seen) abort_run("timeout waiting for fault and done");
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        din          = '0;
        int_en       = '0;
        int_flags_in = '0;
        key_in       = '0;
        seed         = 35;
        n1 = 1 + ($unsigned($random(seed)) % 4);
        n2 = 1 + ($unsigned($random(seed)) % 4);
        load_program();
        repeat (16) @(negedge clk);
        rst    = 1'b0;
        int_en = '1;

        // HALT, then bit 2 and bit 4 together
        wait_read(16'h0011);
        repeat (24) @(negedge clk);
        int_flags_in = 5'b10100;
        wait_flag_clear();
        @(negedge clk);
        int_flags_in = '0;

        // STOP at the vector, woken by a key with IE clear
        wait_read(16'h0050);
        repeat (24) @(negedge clk);
        int_en = '0;
        key_in = 8'h01;
        wait_read(16'h0051);
        key_in = '0;

        // Flags raised once DI has taken effect
        wait_read(16'h0053);
        int_en       = '1;
        int_flags_in = 5'b00001;
        wait_end();
        @(negedge clk);
        if (u_cpu_top.u_cpu_asserts.any_failed) begin
            abort_run("an assertion in cpu_asserts failed");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* verif/cpu_asserts.sv */
`include "cpu_cfg.svh"

module cpu_asserts (
    input logic                   clk,
    input logic                   rst,
    input logic                   phi,
    input logic [`CPU_ADDR_W-1:0] a,
    input logic [`CPU_DATA_W-1:0] dout,
    input logic [`CPU_DATA_W-1:0] din,
    input logic                   rd,
    input logic                   wr,
    input logic [`CPU_INT_N-1:0]  int_en,
    input logic [`CPU_INT_N-1:0]  int_flags_in,
    input logic [`CPU_INT_N-1:0]  int_flags_out,
    input logic [`CPU_DATA_W-1:0] key_in,
    input logic                   done,
    input logic                   fault
);

    localparam int AW = `CPU_ADDR_W;

    logic                  rd_q;
    logic                  wr_q;
    logic                  rd_rise;
    logic                  wr_rise;
    logic                  fetched;     // Opcode byte in op_cap
    logic                  pulse;       // Serviced flag shown cleared
    logic [7:0]            op_cap;
    logic                  is_rst_op;
    logic                  known;
    logic [AW-1:0]         exp_rd;      // Next fetch address
    logic [AW-1:0]         sp_m;
    logic [AW-1:0]         rst_vec;
    logic [AW-1:0]         clr_vec;
    logic [1:0]            wcnt;        // Writes since the last fetch
    logic                  rst_m;
    logic                  ime_m;
    logic                  di_m;
    logic                  halt_m;
    logic                  stop_m;
    logic                  irq_due;
    logic [3:0]            unk_cnt;
    logic [`CPU_INT_N-1:0] pend;
    logic [`CPU_INT_N-1:0] lowest;
    logic                  any_failed;

    initial any_failed = 1'b0;

    assign rd_rise   = rd && !rd_q;
    assign wr_rise   = wr && !wr_q;
    assign fetched   = rd_q && !rd;
    assign pulse     = (int_flags_out != int_flags_in);
    assign pend      = int_en & int_flags_in;
    assign lowest    = pend & (~pend + 1'b1);   // Lowest pending bit wins
    assign is_rst_op = (op_cap[7:6] == `CPU_RST_X) && (op_cap[2:0] == `CPU_RST_Z);
    assign known     = is_rst_op || (op_cap inside {`CPU_OP_NOP, `CPU_OP_STOP,
                                                   `CPU_OP_HALT, `CPU_OP_DI, `CPU_OP_EI});

    always_comb begin
        clr_vec = `CPU_INT_VEC_BASE;
        for (int i = 0; i < `CPU_INT_N; i++) begin
            if (lowest[i]) begin
                clr_vec = `CPU_INT_VEC_BASE + AW'(i) * `CPU_INT_VEC_STEP;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Port-level model of the core
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_q    <= 1'b0;
            wr_q    <= 1'b0;
            op_cap  <= '0;
            exp_rd  <= `CPU_RESET_PC;
            sp_m    <= `CPU_RESET_SP;
            rst_vec <= '0;
            wcnt    <= '0;
            rst_m   <= 1'b0;
            ime_m   <= 1'b0;
            di_m    <= 1'b0;
            halt_m  <= 1'b0;
            stop_m  <= 1'b0;
            irq_due <= 1'b0;
            unk_cnt <= '0;
        end else begin
            rd_q <= rd;
            wr_q <= wr;
            if (rd) op_cap <= din;   // Last value is the T2 sample
            if (rd_rise) begin
                exp_rd <= a + 1'b1;
                wcnt   <= '0;
                rst_m  <= 1'b0;
            end
            if (wr_rise) begin
                sp_m <= sp_m - 1'b1;
                wcnt <= wcnt + 1'b1;
                if (wcnt == 2'd1 && rst_m) exp_rd <= rst_vec;
            end
            if (fetched) begin
                case (op_cap)
                    `CPU_OP_EI: begin
                        ime_m <= 1'b1;
                        di_m  <= 1'b0;
                    end
                    `CPU_OP_DI: begin
                        ime_m <= 1'b0;
                        di_m  <= 1'b1;
                    end
                    `CPU_OP_HALT: halt_m <= 1'b1;
                    `CPU_OP_STOP: stop_m <= 1'b1;
                    default: ;
                endcase
                if (is_rst_op) begin
                    rst_m   <= 1'b1;
                    rst_vec <= AW'({op_cap[5:3], 3'b000});   // y times 8
                end
                if (!known) unk_cnt <= 4'd1;
            end
            if (halt_m && (|pend)) begin
                halt_m <= 1'b0;
                if (ime_m) irq_due <= 1'b1;
            end
            if (stop_m && ((|pend) || (|key_in))) stop_m <= 1'b0;
            if (pulse) begin
                ime_m   <= 1'b0;
                irq_due <= 1'b0;
                exp_rd  <= clr_vec;
            end
            if (unk_cnt != 4'd0 && unk_cnt != 4'd8) unk_cnt <= unk_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    a_reset_values: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!rd && !wr && !done && !fault && phi && dout == '0))
        else begin
            $error("outputs are not at their reset values during reset");
            any_failed = 1'b1;
        end

    a_fetch_addr: assert property (@(posedge clk) disable iff (rst)
        rd_rise |-> (a == exp_rd))
        else begin
            $error("mismatch at %0t: a got %h expected %h",
                   $time, $sampled(a), $sampled(exp_rd));
            any_failed = 1'b1;
        end

    // Exactly two pushes after RST or a due interrupt
    a_push_pair: assert property (@(posedge clk) disable iff (rst)
        rd_rise |-> (wcnt == 2'd2) || (wcnt == 2'd0 && !rst_m && !irq_due))
        else begin
            $error("wrong number of stack writes before the next fetch");
            any_failed = 1'b1;
        end

    a_push_addr: assert property (@(posedge clk) disable iff (rst)
        wr_rise |-> (a == sp_m - 1'b1) && (wcnt != 2'd2))
        else begin
            $error("mismatch at %0t: a got %h expected %h",
                   $time, $sampled(a), $sampled(sp_m) - 1'b1);
            any_failed = 1'b1;
        end

    a_push_data: assert property (@(posedge clk) disable iff (rst)
        wr_rise |-> (dout == ((wcnt == 2'd0) ? exp_rd[15:8] : exp_rd[7:0])))
        else begin
            $error("mismatch at %0t: dout got %h expected %h", $time, $sampled(dout),
                   ($sampled(wcnt) == 2'd0) ? $sampled(exp_rd[15:8]) : $sampled(exp_rd[7:0]));
            any_failed = 1'b1;
        end

    a_flag_value: assert property (@(posedge clk) disable iff (rst)
        pulse |-> (int_flags_out == (int_flags_in & ~lowest)))
        else begin
            $error("mismatch at %0t: int_flags_out got %b expected %b", $time,
                   $sampled(int_flags_out), $sampled(int_flags_in & ~lowest));
            any_failed = 1'b1;
        end

    a_flag_context: assert property (@(posedge clk) disable iff (rst)
        pulse |-> (ime_m && wcnt == 2'd2))
        else begin
            $error("flag clear pulse outside of an interrupt entry");
            any_failed = 1'b1;
        end

    a_asleep: assert property (@(posedge clk) disable iff (rst)
        (halt_m || stop_m) |-> !rd)
        else begin
            $error("read issued while the core should be asleep");
            any_failed = 1'b1;
        end

    a_masked: assert property (@(posedge clk) disable iff (rst)
        (di_m && (|pend)) |-> !wr)
        else begin
            $error("write issued after DI while flags are raised");
            any_failed = 1'b1;
        end

    a_fault: assert property (@(posedge clk) disable iff (rst)
        (unk_cnt == 4'd8) |-> fault)
        else begin
            $error("fault did not rise after an unknown opcode");
            any_failed = 1'b1;
        end

    a_done: assert property (@(posedge clk) disable iff (rst)
        $rose(fault) |=> done)
        else begin
            $error("done did not follow fault by one clock");
            any_failed = 1'b1;
        end

endmodule

/* hw/cpu_top.sv */
`include "cpu_cfg.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   phi,
    output logic [`CPU_ADDR_W-1:0] a,
    output logic [`CPU_DATA_W-1:0] dout,
    input  logic [`CPU_DATA_W-1:0] din,
    output logic                   rd,
    output logic                   wr,
    input  logic [`CPU_INT_N-1:0]  int_en,
    input  logic [`CPU_INT_N-1:0]  int_flags_in,
    output logic [`CPU_INT_N-1:0]  int_flags_out,
    input  logic [`CPU_DATA_W-1:0] key_in,
    output logic                   done,
    output logic                   fault
);

    // Arbiter to bus cycle unit
    logic                      bus_req;
    cpu_bus_pkg::bus_req_t     bus_cmd;
    logic                      bus_ack;
    cpu_bus_pkg::bus_rsp_t     bus_rsp;

    // Requester links
    logic                      f_req;
    cpu_bus_pkg::bus_req_t     f_cmd;
    logic                      f_ack;
    cpu_bus_pkg::bus_rsp_t     f_rsp;
    logic                      r_req;
    cpu_bus_pkg::bus_req_t     r_cmd;
    logic                      r_ack;

    // Fetch to restart
    logic                      rs_req;
    cpu_isa_pkg::restart_req_t rs_cmd;
    logic                      rs_ack;
    cpu_isa_pkg::pc_load_t     pc_load;
    logic                      ime_set;
    logic                      ime_clr;
    logic                      boundary;
    logic                      halted;
    logic                      stopped;

    bus_cycle_unit u_bus_cycle_unit (
        .clk, .rst,
        .req (bus_req), .cmd (bus_cmd), .ack (bus_ack), .rsp (bus_rsp),
        .phi, .a, .dout, .rd, .wr, .din
    );

    bus_arbiter u_bus_arbiter (
        .clk, .rst,
        .rst_side_req (r_req), .rst_side_cmd (r_cmd),
        .rst_side_ack (r_ack), .rst_side_rsp (),   // Writes only, no data back
        .fetch_req (f_req), .fetch_cmd (f_cmd), .fetch_ack (f_ack), .fetch_rsp (f_rsp),
        .bus_req, .bus_cmd, .bus_ack, .bus_rsp
    );

    fetch_unit u_fetch_unit (
        .clk, .rst,
        .bus_req (f_req), .bus_cmd (f_cmd), .bus_ack (f_ack), .bus_rsp (f_rsp),
        .rst_req (rs_req), .rst_cmd (rs_cmd), .rst_ack (rs_ack),
        .pc_load, .ime_set, .ime_clr, .boundary,
        .int_en, .int_flags_in, .key_in,
        .halted, .stopped, .fault
    );

    restart_unit u_restart_unit (
        .clk, .rst,
        .bus_req (r_req), .bus_cmd (r_cmd), .bus_ack (r_ack),
        .rst_req (rs_req), .rst_cmd (rs_cmd), .rst_ack (rs_ack),
        .pc_load,
        .pc (f_cmd.addr),   // Fetch address is the live PC
        .boundary, .ime_set, .ime_clr,
        .int_en, .int_flags_in, .int_flags_out
    );

    // One clock behind the sleep and fault states
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= halted | stopped | fault;
        end
    end

endmodule

/* hw/restart_unit.sv */
`include "cpu_cfg.svh"

module restart_unit (
    input  logic                        clk,
    input  logic                        rst,
    output logic                        bus_req,
    output cpu_bus_pkg::bus_req_t       bus_cmd,
    input  logic                        bus_ack,
    input  logic                        rst_req,
    input  cpu_isa_pkg::restart_req_t   rst_cmd,
    output logic                        rst_ack,
    output cpu_isa_pkg::pc_load_t       pc_load,
    input  logic [`CPU_ADDR_W-1:0]      pc,
    input  logic                        boundary,
    input  logic                        ime_set,
    input  logic                        ime_clr,
    input  logic [`CPU_INT_N-1:0]       int_en,
    input  logic [`CPU_INT_N-1:0]       int_flags_in,
    output logic [`CPU_INT_N-1:0]       int_flags_out
);

    localparam int AW = `CPU_ADDR_W;
    localparam int DW = `CPU_DATA_W;
    localparam int IN = `CPU_INT_N;
    localparam int IW = $clog2(IN);

    typedef enum logic [2:0] {
        R_IDLE,
        R_PUSH,   // Write in flight
        R_DROP,   // Waits for ack to fall
        R_LOAD,   // PC load issued here
        R_ACK     // RST only, closes the restart handshake
    } rstate_e;

    rstate_e       state;
    logic [AW-1:0] sp;
    logic          ime;
    logic          lo_byte;   // Second push carries the low byte
    logic          is_int;
    logic [AW-1:0] ret_pc;
    logic [AW-1:0] target;
    logic [IN-1:0] clr_mask;
    logic [IN-1:0] pending;
    logic [IW-1:0] int_idx;
    logic [AW-1:0] int_vec;

    //////////////////////////////////////////////////////////////////////
    // Interrupt priority
    //////////////////////////////////////////////////////////////////////

    assign pending = int_en & int_flags_in & {IN{ime}};

    // Walk downward so the lowest set bit ends up selected
    always_comb begin
        int_idx = '0;
        for (int i = IN - 1; i >= 0; i--) begin
            if (pending[i]) int_idx = IW'(i);
        end
    end

    assign int_vec = `CPU_INT_VEC_BASE + AW'(int_idx) * `CPU_INT_VEC_STEP;

    //////////////////////////////////////////////////////////////////////
    // Push sequence
    //////////////////////////////////////////////////////////////////////

    assign bus_cmd.kind  = cpu_bus_pkg::CYC_WRITE;
    assign bus_cmd.addr  = sp - 1'b1;   // Pre-decrement
    assign bus_cmd.wdata = lo_byte ? ret_pc[DW-1:0] : ret_pc[AW-1 -: DW];

    assign pc_load.valid = (state == R_LOAD);
    assign pc_load.pc    = target;

    assign int_flags_out = (state == R_LOAD && is_int) ? (int_flags_in & ~clr_mask)
                                                       : int_flags_in;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= R_IDLE;
            sp      <= `CPU_RESET_SP;
            ime     <= 1'b0;
            lo_byte <= 1'b0;
            is_int  <= 1'b0;
            bus_req <= 1'b0;
            rst_ack <= 1'b0;
        end else begin
            if (ime_set) ime <= 1'b1;
            else if (ime_clr) ime <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (rst_req) begin
                        is_int  <= 1'b0;
                        lo_byte <= 1'b0;
                        bus_req <= 1'b1;
                        state   <= R_PUSH;
                    end else if (boundary && (|pending)) begin
                        ime     <= 1'b0;   // Entry masks further interrupts
                        is_int  <= 1'b1;
                        lo_byte <= 1'b0;
                        bus_req <= 1'b1;
                        state   <= R_PUSH;
                    end
                end
                R_PUSH: if (bus_ack) begin
                    bus_req <= 1'b0;
                    sp      <= sp - 1'b1;
                    state   <= R_DROP;
                end
                R_DROP: if (!bus_ack) begin
                    if (lo_byte) begin
                        state <= R_LOAD;
                    end else begin
                        lo_byte <= 1'b1;
                        bus_req <= 1'b1;
                        state   <= R_PUSH;
                    end
                end
                R_LOAD: begin
                    if (is_int) begin
                        state <= R_IDLE;
                    end else begin
                        rst_ack <= 1'b1;
                        state   <= R_ACK;
                    end
                end
                R_ACK: if (!rst_req) begin
                    rst_ack <= 1'b0;
                    state   <= R_IDLE;
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // Return PC, target and serviced bit, captured while idle
    always_ff @(posedge clk) begin
        if (state == R_IDLE) begin
            if (rst_req) begin
                ret_pc <= rst_cmd.ret_pc;
                target <= rst_cmd.target;
            end else begin
                ret_pc   <= pc;
                target   <= int_vec;
                clr_mask <= IN'(1) << int_idx;
            end
        end
    end

endmodule

/* hw/fetch_unit.sv */
`include "cpu_cfg.svh"

module fetch_unit (
    input  logic                        clk,
    input  logic                        rst,
    output logic                        bus_req,
    output cpu_bus_pkg::bus_req_t       bus_cmd,
    input  logic                        bus_ack,
    input  cpu_bus_pkg::bus_rsp_t       bus_rsp,
    output logic                        rst_req,
    output cpu_isa_pkg::restart_req_t   rst_cmd,
    input  logic                        rst_ack,
    input  cpu_isa_pkg::pc_load_t       pc_load,
    output logic                        ime_set,
    output logic                        ime_clr,
    output logic                        boundary,
    input  logic [`CPU_INT_N-1:0]       int_en,
    input  logic [`CPU_INT_N-1:0]       int_flags_in,
    input  logic [`CPU_DATA_W-1:0]      key_in,
    output logic                        halted,
    output logic                        stopped,
    output logic                        fault
);

    localparam int AW = `CPU_ADDR_W;

    typedef enum logic [2:0] {
        S_BOUND,    // Between instructions
        S_FETCH,    // Opcode read in flight
        S_DECODE,   // Waits for ack to fall, then decodes
        S_RST,      // RST handed to restart unit
        S_RST_DONE,
        S_HALT,
        S_STOP,
        S_FAULT
    } fstate_e;

    fstate_e              state;
    logic [AW-1:0]        pc;
    cpu_isa_pkg::opcode_u op_q;
    logic                 is_rst;
    logic                 wake_halt;
    logic                 wake_stop;

    // IME plays no part in waking up
    assign wake_halt = |(int_en & int_flags_in);
    assign wake_stop = wake_halt || (|key_in);

    assign is_rst = (op_q.f.x == `CPU_RST_X) && (op_q.f.z == `CPU_RST_Z);

    // Fetch address follows PC, restart unit reads it from here too
    assign bus_cmd.kind  = cpu_bus_pkg::CYC_READ;
    assign bus_cmd.addr  = pc;
    assign bus_cmd.wdata = '0;

    assign boundary = (state == S_BOUND);
    assign halted   = (state == S_HALT);
    assign stopped  = (state == S_STOP);
    assign fault    = (state == S_FAULT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_BOUND;
            pc      <= `CPU_RESET_PC;
            bus_req <= 1'b0;
            rst_req <= 1'b0;
            ime_set <= 1'b0;
            ime_clr <= 1'b0;
        end else begin
            ime_set <= 1'b0;
            ime_clr <= 1'b0;
            if (pc_load.valid) pc <= pc_load.pc;   // RST or interrupt entry
            case (state)
                S_BOUND: begin
                    bus_req <= 1'b1;
                    state   <= S_FETCH;
                end
                S_FETCH: if (bus_ack) begin
                    bus_req <= 1'b0;
                    pc      <= pc + 1'b1;
                    state   <= S_DECODE;
                end
                S_DECODE: if (!bus_ack) begin
                    if (is_rst) begin
                        rst_req <= 1'b1;
                        state   <= S_RST;
                    end else begin
                        case (op_q.raw)
                            `CPU_OP_NOP:  state <= S_BOUND;
                            `CPU_OP_HALT: state <= S_HALT;
                            `CPU_OP_STOP: state <= S_STOP;
                            `CPU_OP_DI: begin
                                ime_clr <= 1'b1;
                                state   <= S_BOUND;
                            end
                            `CPU_OP_EI: begin
                                ime_set <= 1'b1;
                                state   <= S_BOUND;
                            end
                            default: state <= S_FAULT;   // Unknown opcode
                        endcase
                    end
                end
                S_RST: if (rst_ack) begin
                    rst_req <= 1'b0;
                    state   <= S_RST_DONE;
                end
                S_RST_DONE: if (!rst_ack) state <= S_BOUND;
                S_HALT: if (wake_halt) state <= S_BOUND;
                S_STOP: if (wake_stop) state <= S_BOUND;
                S_FAULT: ;   // Dead until reset
                default: state <= S_FAULT;
            endcase
        end
    end

    // Opcode byte and restart payload
    always_ff @(posedge clk) begin
        if (state == S_FETCH && bus_ack) op_q.raw <= bus_rsp.rdata;
        if (state == S_DECODE) begin
            rst_cmd.target <= AW'({op_q.f.y, 3'b000});
            rst_cmd.ret_pc <= pc;
        end
    end

endmodule

/* hw/bus_arbiter.sv */
module bus_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    // Restart unit, higher priority
    input  logic                  rst_side_req,
    input  cpu_bus_pkg::bus_req_t rst_side_cmd,
    output logic                  rst_side_ack,
    output cpu_bus_pkg::bus_rsp_t rst_side_rsp,
    // Fetch unit
    input  logic                  fetch_req,
    input  cpu_bus_pkg::bus_req_t fetch_cmd,
    output logic                  fetch_ack,
    output cpu_bus_pkg::bus_rsp_t fetch_rsp,
    // Toward the bus cycle unit
    output logic                  bus_req,
    output cpu_bus_pkg::bus_req_t bus_cmd,
    input  logic                  bus_ack,
    input  cpu_bus_pkg::bus_rsp_t bus_rsp
);

    typedef enum logic [1:0] {
        G_NONE,
        G_RST,
        G_FETCH
    } grant_e;

    grant_e grant;

    // Grant is released only once the whole handshake has closed
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant <= G_NONE;
        end else begin
            case (grant)
                G_NONE: begin
                    if (rst_side_req) grant <= G_RST;
                    else if (fetch_req) grant <= G_FETCH;
                end
                G_RST:   if (!rst_side_req && !bus_ack) grant <= G_NONE;
                G_FETCH: if (!fetch_req && !bus_ack) grant <= G_NONE;
                default: grant <= G_NONE;
            endcase
        end
    end

    always_comb begin
        bus_req      = 1'b0;
        bus_cmd      = '0;
        rst_side_ack = 1'b0;
        rst_side_rsp = '0;
        fetch_ack    = 1'b0;
        fetch_rsp    = '0;
        case (grant)
            G_RST: begin
                bus_req      = rst_side_req;
                bus_cmd      = rst_side_cmd;
                rst_side_ack = bus_ack;
                rst_side_rsp = bus_rsp;
            end
            G_FETCH: begin
                bus_req   = fetch_req;
                bus_cmd   = fetch_cmd;
                fetch_ack = bus_ack;
                fetch_rsp = bus_rsp;
            end
            default: ;
        endcase
    end

endmodule

/* hw/bus_cycle_unit.sv */
`include "cpu_cfg.svh"

module bus_cycle_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  cpu_bus_pkg::bus_req_t  cmd,
    output logic                   ack,
    output cpu_bus_pkg::bus_rsp_t  rsp,
    output logic                   phi,
    output logic [`CPU_ADDR_W-1:0] a,
    output logic [`CPU_DATA_W-1:0] dout,
    output logic                   rd,
    output logic                   wr,
    input  logic [`CPU_DATA_W-1:0] din
);

    // Each state names the T-state acted on at the next edge
    typedef enum logic [2:0] {
        S_T0,    // Idle, waiting for a granted request
        S_T1,
        S_T2,
        S_T3,
        S_HOLD   // Ack high until req falls
    } tstate_e;

    tstate_e state;
    logic    is_read;

    assign is_read = (cmd.kind == cpu_bus_pkg::CYC_READ);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_T0;
            ack   <= 1'b0;
            phi   <= 1'b1;
            a     <= '0;
            dout  <= '0;
            rd    <= 1'b0;
            wr    <= 1'b0;
        end else begin
            case (state)
                S_T0: if (req) begin
                    a     <= cmd.addr;   // Address setup
                    rd    <= is_read;
                    phi   <= 1'b1;
                    state <= S_T1;
                end
                S_T1: state <= S_T2;     // Bus settles
                S_T2: begin
                    if (!is_read) begin
                        wr   <= 1'b1;
                        dout <= cmd.wdata;
                    end
                    rd    <= 1'b0;
                    phi   <= 1'b0;
                    state <= S_T3;
                end
                S_T3: begin
                    rd    <= 1'b0;
                    wr    <= 1'b0;
                    dout  <= '0;
                    ack   <= 1'b1;
                    state <= S_HOLD;
                end
                S_HOLD: if (!req) begin
                    ack   <= 1'b0;
                    state <= S_T0;
                end
                default: state <= S_T0;
            endcase
        end
    end

    // Read data sampled at T2
    always_ff @(posedge clk) begin
        if (state == S_T2 && is_read) begin
            rsp.rdata <= din;
        end
    end

endmodule

/* hw/cpu_isa_pkg.sv */
`include "cpu_cfg.svh"

package cpu_isa_pkg;

    // Classic x/y/z split of an opcode byte
    typedef struct packed {
        logic [1:0] x;
        logic [2:0] y;
        logic [2:0] z;
    } opcode_fields_t;

    // Same byte, seen raw or as fields
    typedef union packed {
        logic [`CPU_DATA_W-1:0] raw;
        opcode_fields_t         f;
    } opcode_u;

    // Fetch unit to restart unit, one per RST
    typedef struct packed {
        logic [`CPU_ADDR_W-1:0] target;   // Vector to jump to
        logic [`CPU_ADDR_W-1:0] ret_pc;   // Pushed on the stack
    } restart_req_t;

    // Restart unit to fetch unit, valid for a single clock
    typedef struct packed {
        logic                   valid;
        logic [`CPU_ADDR_W-1:0] pc;
    } pc_load_t;

endpackage

/* hw/cpu_bus_pkg.sv */
`include "cpu_cfg.svh"

package cpu_bus_pkg;

    // Direction of one machine cycle
    typedef enum logic {
        CYC_READ  = 1'b0,
        CYC_WRITE = 1'b1
    } cycle_kind_e;

    // Held stable by the requester while req is high
    typedef struct packed {
        cycle_kind_e             kind;
        logic [`CPU_ADDR_W-1:0]  addr;
        logic [`CPU_DATA_W-1:0]  wdata;   // Ignored on reads
    } bus_req_t;

    // Valid while ack is high
    typedef struct packed {
        logic [`CPU_DATA_W-1:0]  rdata;
    } bus_rsp_t;

endpackage

/* hw/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Bus and interrupt sizes
//////////////////////////////////////////////////////////////////////

`define CPU_ADDR_W 16
`define CPU_DATA_W 8

// Lowest bit wins when several are pending
`define CPU_INT_N 5

// Register values after reset
`define CPU_RESET_PC 16'h0000
`define CPU_RESET_SP 16'hFFFE

// Interrupt i enters at base + i * step
`define CPU_INT_VEC_BASE 16'h0040
`define CPU_INT_VEC_STEP 16'd8

//////////////////////////////////////////////////////////////////////
// Opcode subset
//////////////////////////////////////////////////////////////////////

`define CPU_OP_NOP  8'h00
`define CPU_OP_STOP 8'h10
`define CPU_OP_HALT 8'h76
`define CPU_OP_DI   8'hF3
`define CPU_OP_EI   8'hFB

// RST n matches these x/z fields, y picks the vector
`define CPU_RST_X 2'd3
`define CPU_RST_Z 3'd7

`endif
